/* decode_ctrl_if.sv */
`timescale 1ns/1ps

interface decode_ctrl_if;
    logic       br;           // conditional branch
    logic [1:0] jp;           // none, immediate target or register target
    logic       alu_in_b;     // second alu operand is the immediate
    logic       dm_we;        // data memory write
    logic       r_we;         // register file write
    logic [1:0] r_dst;        // rt, rd or r31
    logic [1:0] rw_d;         // writeback from alu, memory or pc
    logic [1:0] imm_len;      // 16 bit, 26 bit or shift amount
    logic       imm_sign_ext; // sign extend the 16 bit immediate
    logic [1:0] mem_size;     // word, half or byte access
    logic       mem_sign_ext; // sign extend the loaded value
    logic [1:0] hi_lo_out;    // result from alu, hi or lo
    logic       hi_in;        // load hi
    logic       lo_in;        // load lo
    logic       not_impl;     // word outside the decoded set

    modport source (
        output br, jp, alu_in_b, dm_we, r_we, r_dst, rw_d, imm_len, imm_sign_ext,
        output mem_size, mem_sign_ext, hi_lo_out, hi_in, lo_in, not_impl
    );

    modport sink (
        input br, jp, alu_in_b, dm_we, r_we, r_dst, rw_d, imm_len, imm_sign_ext,
        input mem_size, mem_sign_ext, hi_lo_out, hi_in, lo_in, not_impl
    );
endinterface

/* filelist.f */
+incdir+.
mips_decode_pkg.sv
decode_ctrl_if.sv
insn_control.sv
insn_field_reg.sv
mips_decode.sv
mips_decode_checker.sv
tb_mips_decode.sv

/* insn_control.sv */
`timescale 1ns/1ps

`include "mips_decode_consts.svh"

module insn_control
    import mips_decode_pkg::*;
(
    input  logic          clk,
    input  logic          i_reset,
    input  insn_word_u    i_insn,
    decode_ctrl_if.source ctrl
);

    logic       n_br;
    logic [1:0] n_jp;
    logic       n_alu_in_b;
    logic       n_dm_we;
    logic       n_r_we;
    logic [1:0] n_r_dst;
    logic [1:0] n_rw_d;
    logic [1:0] n_imm_len;
    logic       n_imm_sign_ext;
    logic [1:0] n_mem_size;
    logic       n_mem_sign_ext;
    logic [1:0] n_hi_lo_out;
    logic       n_hi_in;
    logic       n_lo_in;
    logic       n_not_impl;
    logic       is_nop;

    // the all-zero word would otherwise look like sll r0, r0, 0
    assign is_nop = (i_insn.j.opcode == '0) && (i_insn.j.imm26 == '0);

    always_comb begin
        n_br           = 1'b0;       // defaults describe an instruction that does nothing
        n_jp           = `JP_NONE;
        n_alu_in_b     = 1'b0;
        n_dm_we        = 1'b0;
        n_r_we         = 1'b0;
        n_r_dst        = `DST_RT;
        n_rw_d         = `WB_ALU;
        n_imm_len      = `LEN_16;
        n_imm_sign_ext = 1'b1;       // immediates are signed unless the op is logical
        n_mem_size     = `SIZE_WORD;
        n_mem_sign_ext = 1'b1;
        n_hi_lo_out    = `HL_ALU;
        n_hi_in        = 1'b0;
        n_lo_in        = 1'b0;
        n_not_impl     = 1'b0;
        if (!is_nop) begin
            case (i_insn.r.opcode)
                `OP_SPECIAL: begin
                    case (i_insn.r.funct)
                        `FN_SLL, `FN_SRL, `FN_SRA: begin
                            n_alu_in_b = 1'b1;   // shift amount is the b operand
                            n_r_we     = 1'b1;
                            n_r_dst    = `DST_RD;
                            n_imm_len  = `LEN_SA;
                        end
                        `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
                            n_r_we    = 1'b1;    // amount comes from rs here
                            n_r_dst   = `DST_RD;
                            n_imm_len = `LEN_SA;
                        end
                        `FN_JR: n_jp = `JP_REG;
                        `FN_JALR: begin
                            n_jp    = `JP_REG;
                            n_r_we  = 1'b1;      // link address goes to rd
                            n_rw_d  = `WB_PC;
                            n_r_dst = `DST_RD;
                        end
                        `FN_MFHI, `FN_MFLO: begin
                            n_r_we      = 1'b1;
                            n_r_dst     = `DST_RD;
                            n_hi_lo_out = (i_insn.r.funct == `FN_MFHI) ? `HL_HI : `HL_LO;
                        end
                        `FN_MTHI: n_hi_in = 1'b1;
                        `FN_MTLO: n_lo_in = 1'b1;
                        `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: begin
                            n_hi_in = 1'b1;      // both halves of the product or quotient
                            n_lo_in = 1'b1;
                        end
                        `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
                        `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU: begin
                            n_r_we  = 1'b1;      // plain three-register alu op
                            n_r_dst = `DST_RD;
                        end
                        default: n_not_impl = 1'b1;
                    endcase
                end
                `OP_REGIMM: begin
                    case (i_insn.i.rt)           // rt holds the sub-opcode here
                        `RT_BLTZ, `RT_BGEZ: n_br = 1'b1;
                        default:            n_not_impl = 1'b1;
                    endcase
                end
                `OP_J, `OP_JAL: begin
                    n_jp      = `JP_IMM;
                    n_imm_len = `LEN_26;
                    if (i_insn.r.opcode == `OP_JAL) begin
                        n_r_dst = `DST_R31;      // jal links through r31
                        n_r_we  = 1'b1;
                        n_rw_d  = `WB_PC;
                    end
                end
                `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: n_br = 1'b1;
                `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
                    n_alu_in_b = 1'b1;
                    n_r_we     = 1'b1;
                end
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                    n_alu_in_b     = 1'b1;
                    n_r_we         = 1'b1;
                    n_imm_sign_ext = 1'b0;       // logical immediates are zero extended
                end
                `OP_SPECIAL2: begin
                    if (i_insn.r.funct == `FN_MUL) begin
                        n_r_we  = 1'b1;
                        n_r_dst = `DST_RD;
                    end else begin
                        n_not_impl = 1'b1;
                    end
                end
                `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                    n_alu_in_b = 1'b1;           // address is base plus offset
                    n_r_we     = 1'b1;
                    n_rw_d     = `WB_MEM;
                    if (i_insn.i.opcode == `OP_LB || i_insn.i.opcode == `OP_LBU)
                        n_mem_size = `SIZE_BYTE;
                    if (i_insn.i.opcode == `OP_LH || i_insn.i.opcode == `OP_LHU)
                        n_mem_size = `SIZE_HALF;
                    if (i_insn.i.opcode == `OP_LBU || i_insn.i.opcode == `OP_LHU)
                        n_mem_sign_ext = 1'b0;   // unsigned loads pad with zeros
                end
                `OP_SB, `OP_SH, `OP_SW: begin
                    n_alu_in_b = 1'b1;
                    n_dm_we    = 1'b1;
                    if (i_insn.i.opcode == `OP_SB)
                        n_mem_size = `SIZE_BYTE;
                    else if (i_insn.i.opcode == `OP_SH)
                        n_mem_size = `SIZE_HALF;
                end
                default: n_not_impl = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ctrl.br           <= 1'b0;
            ctrl.jp           <= `JP_NONE;
            ctrl.alu_in_b     <= 1'b0;
            ctrl.dm_we        <= 1'b0;
            ctrl.r_we         <= 1'b0;
            ctrl.r_dst        <= `DST_RT;
            ctrl.rw_d         <= `WB_ALU;
            ctrl.imm_len      <= `LEN_16;
            ctrl.imm_sign_ext <= 1'b1;      // same as the decode default
            ctrl.mem_size     <= `SIZE_WORD;
            ctrl.mem_sign_ext <= 1'b1;
            ctrl.hi_lo_out    <= `HL_ALU;
            ctrl.hi_in        <= 1'b0;
            ctrl.lo_in        <= 1'b0;
            ctrl.not_impl     <= 1'b0;
        end else begin
            ctrl.br           <= n_br;
            ctrl.jp           <= n_jp;
            ctrl.alu_in_b     <= n_alu_in_b;
            ctrl.dm_we        <= n_dm_we;
            ctrl.r_we         <= n_r_we;
            ctrl.r_dst        <= n_r_dst;
            ctrl.rw_d         <= n_rw_d;
            ctrl.imm_len      <= n_imm_len;
            ctrl.imm_sign_ext <= n_imm_sign_ext;
            ctrl.mem_size     <= n_mem_size;
            ctrl.mem_sign_ext <= n_mem_sign_ext;
            ctrl.hi_lo_out    <= n_hi_lo_out;
            ctrl.hi_in        <= n_hi_in;
            ctrl.lo_in        <= n_lo_in;
            ctrl.not_impl     <= n_not_impl;
        end
    end

endmodule

/* insn_field_reg.sv */
`timescale 1ns/1ps

`include "mips_decode_consts.svh"

module insn_field_reg
    import mips_decode_pkg::*;
(
    input  logic                clk,
    input  insn_word_u          i_insn,
    input  logic [`WORD_W-1:0]  i_pc,
    output logic [`REG_W-1:0]   o_rs,
    output logic [`REG_W-1:0]   o_rt,
    output logic [`IMM16_W-1:0] o_imm16,
    output logic [`IMM26_W-1:0] o_imm26,
    output logic [`SA_W-1:0]    o_sa,
    output logic [`WORD_W-1:0]  o_pc,
    output logic [`WORD_W-1:0]  o_insn
);

    // register numbers go to the register file in the same cycle
    assign o_rs = i_insn.i.rs;
    assign o_rt = i_insn.i.rt;

    always_ff @(posedge clk) begin
        o_imm16 <= i_insn.i.imm16;  // extension is left to the next stage
        o_imm26 <= i_insn.j.imm26;  // jump target bits before the shift by two
        o_sa    <= i_insn.r.sa;
        o_pc    <= i_pc;            // pc travels with its instruction
        o_insn  <= i_insn;          // whole word kept for later stages
    end

endmodule

/* mips_decode.sv */
`timescale 1ns/1ps

`include "mips_decode_consts.svh"

module mips_decode (
    input  logic                clk,
    input  logic                i_reset,
    input  logic [`WORD_W-1:0]  i_insn,
    input  logic [`WORD_W-1:0]  i_pc,
    output logic [`REG_W-1:0]   o_rs,
    output logic [`REG_W-1:0]   o_rt,
    output logic [`IMM16_W-1:0] o_imm16,
    output logic [`IMM26_W-1:0] o_imm26,
    output logic [`SA_W-1:0]    o_sa,
    output logic                o_br,
    output logic [1:0]          o_jp,
    output logic                o_alu_in_b,
    output logic                o_dm_we,
    output logic                o_r_we,
    output logic [1:0]          o_r_dst,
    output logic [1:0]          o_rw_d,
    output logic [1:0]          o_imm_len,
    output logic                o_imm_sign_ext,
    output logic [1:0]          o_mem_size,
    output logic                o_mem_sign_ext,
    output logic [1:0]          o_hi_lo_out,
    output logic                o_hi_in,
    output logic                o_lo_in,
    output logic                o_not_impl,
    output logic [`WORD_W-1:0]  o_pc,
    output logic [`WORD_W-1:0]  o_insn
);

    decode_ctrl_if ctrl ();  // registered control fields from the decoder

    insn_control u_control (
        .clk     (clk),
        .i_reset (i_reset),
        .i_insn  (i_insn),
        .ctrl    (ctrl.source)
    );

    insn_field_reg u_fields (
        .clk     (clk),
        .i_insn  (i_insn),
        .i_pc    (i_pc),
        .o_rs    (o_rs),
        .o_rt    (o_rt),
        .o_imm16 (o_imm16),
        .o_imm26 (o_imm26),
        .o_sa    (o_sa),
        .o_pc    (o_pc),
        .o_insn  (o_insn)
    );

    assign o_br           = ctrl.br;
    assign o_jp           = ctrl.jp;
    assign o_alu_in_b     = ctrl.alu_in_b;
    assign o_dm_we        = ctrl.dm_we;
    assign o_r_we         = ctrl.r_we;
    assign o_r_dst        = ctrl.r_dst;
    assign o_rw_d         = ctrl.rw_d;
    assign o_imm_len      = ctrl.imm_len;
    assign o_imm_sign_ext = ctrl.imm_sign_ext;
    assign o_mem_size     = ctrl.mem_size;
    assign o_mem_sign_ext = ctrl.mem_sign_ext;
    assign o_hi_lo_out    = ctrl.hi_lo_out;
    assign o_hi_in        = ctrl.hi_in;
    assign o_lo_in        = ctrl.lo_in;
    assign o_not_impl     = ctrl.not_impl;  // stays aligned with the other fields

endmodule

/* mips_decode_checker.sv */
`timescale 1ns/1ps

`include "mips_decode_consts.svh"

module mips_decode_checker (
    input logic       clk,
    input logic       i_reset,
    input logic       o_br,
    input logic [1:0] o_jp,
    input logic       o_dm_we,
    input logic       o_r_we,
    input logic [1:0] o_r_dst,
    input logic [1:0] o_rw_d,
    input logic [1:0] o_mem_size,
    input logic [1:0] o_hi_lo_out,
    input logic       o_hi_in,
    input logic       o_lo_in,
    input logic       o_not_impl
);

    // every enable must come out of reset low
    reset_clears_enables: assert property (@(posedge clk)
        i_reset |=> !(o_br || o_dm_we || o_r_we || o_hi_in || o_lo_in))
        else $error("an enable is high in the cycle after reset");

    // code 3 is unused in every two-bit control field
    no_unused_codes: assert property (@(posedge clk) disable iff (i_reset)
        o_jp != 2'd3 && o_r_dst != 2'd3 && o_rw_d != 2'd3 &&
        o_mem_size != 2'd3 && o_hi_lo_out != 2'd3)
        else $error("a two-bit control field holds the unused code 3");

    no_store_and_reg_write: assert property (@(posedge clk) disable iff (i_reset)
        !(o_dm_we && o_r_we))
        else $error("memory write and register write are high together");

    // a word outside the decoded set must not change any state
    not_impl_is_inert: assert property (@(posedge clk) disable iff (i_reset)
        o_not_impl |-> !(o_dm_we || o_r_we || o_hi_in || o_lo_in || o_br ||
                         o_jp != `JP_NONE))
        else $error("unimplemented word drives an enable, branch or jump");

endmodule

bind mips_decode mips_decode_checker u_checker (.*);

/* mips_decode_consts.svh */
`ifndef MIPS_DECODE_CONSTS_SVH
`define MIPS_DECODE_CONSTS_SVH

`define WORD_W      32
`define REG_W       5
`define IMM16_W     16
`define IMM26_W     26
`define SA_W        5
`define OPC_W       6
`define FN_W        6

`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_SPECIAL2 6'h1c
`define OP_LB       6'h20
`define OP_LH       6'h21
`define OP_LW       6'h23
`define OP_LBU      6'h24
`define OP_LHU      6'h25
`define OP_SB       6'h28
`define OP_SH       6'h29
`define OP_SW       6'h2b

`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06
`define FN_SRAV     6'h07
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_MFHI     6'h10
`define FN_MTHI     6'h11
`define FN_MFLO     6'h12
`define FN_MTLO     6'h13
`define FN_MULT     6'h18
`define FN_MULTU    6'h19
`define FN_DIV      6'h1a
`define FN_DIVU     6'h1b
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b
`define FN_MUL      6'h02

`define RT_BLTZ     5'h00
`define RT_BGEZ     5'h01

`define JP_NONE     2'd0
`define JP_IMM      2'd1
`define JP_REG      2'd2

`define DST_RT      2'd0
`define DST_RD      2'd1
`define DST_R31     2'd2

`define WB_ALU      2'd0
`define WB_MEM      2'd1
`define WB_PC       2'd2

`define LEN_16      2'd0
`define LEN_26      2'd1
`define LEN_SA      2'd2

`define SIZE_WORD   2'd0
`define SIZE_HALF   2'd1
`define SIZE_BYTE   2'd2

`define HL_ALU      2'd0
`define HL_HI       2'd1
`define HL_LO       2'd2

`endif

/* mips_decode_pkg.sv */
package mips_decode_pkg;

`include "mips_decode_consts.svh"

    typedef struct packed {
        logic [`OPC_W-1:0] opcode; // major opcode, same spot in every format
        logic [`REG_W-1:0] rs;     // first source register
        logic [`REG_W-1:0] rt;     // second source or immediate-form destination
        logic [`REG_W-1:0] rd;     // register-form destination
        logic [`SA_W-1:0]  sa;     // constant shift amount
        logic [`FN_W-1:0]  funct;  // selects the operation inside SPECIAL and SPECIAL2
    } insn_r_t;

    typedef struct packed {
        logic [`OPC_W-1:0]   opcode;
        logic [`REG_W-1:0]   rs;    // base register for loads and stores
        logic [`REG_W-1:0]   rt;    // also carries the REGIMM sub-opcode
        logic [`IMM16_W-1:0] imm16; // offset or ALU immediate
    } insn_i_t;

    typedef struct packed {
        logic [`OPC_W-1:0]   opcode;
        logic [`IMM26_W-1:0] imm26; // word index of the jump target
    } insn_j_t;

    // one instruction word seen through the three encoding formats
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
        insn_j_t j;
    } insn_word_u;

endpackage

/* tb_mips_decode.sv */
`timescale 1ns/1ps

`include "mips_decode_consts.svh"

module tb_mips_decode;

    localparam int N_INSN = 2000;
    localparam int RESET_CYCLES = 16;

    logic clk = 1'b0;
    logic i_reset;
    logic [31:0] i_insn, i_pc;
    logic [4:0] o_rs, o_rt, o_sa;
    logic [15:0] o_imm16;
    logic [25:0] o_imm26;
    logic o_br, o_alu_in_b, o_dm_we, o_r_we, o_imm_sign_ext, o_mem_sign_ext;
    logic o_hi_in, o_lo_in, o_not_impl;
    logic [1:0] o_jp, o_r_dst, o_rw_d, o_imm_len, o_mem_size, o_hi_lo_out;
    logic [31:0] o_pc, o_insn;

    logic exp_br, exp_alu_in_b, exp_dm_we, exp_r_we, exp_imm_sign_ext, exp_mem_sign_ext;
    logic exp_hi_in, exp_lo_in, exp_not_impl;
    logic [1:0] exp_jp, exp_r_dst, exp_rw_d, exp_imm_len, exp_mem_size, exp_hi_lo_out;

    int error_count = 0;
    logic [31:0] rng_state = 32'd28;
    logic [31:0] word, pc;

    logic [5:0] special_fns [0:25] = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV,
        `FN_SRAV, `FN_JR, `FN_JALR, `FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO, `FN_MULT,
        `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
        `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU};
    logic [5:0] other_ops [0:21] = '{`OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ,
        `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
        `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};

    mips_decode UUT (.*);

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // mostly listed codes on random fields, with some zero and fully random words
    task automatic gen_insn(output logic [31:0] w);
        logic [31:0] a, b;
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        case (a[3:0])
            4'd0:                      w = '0;
            4'd1, 4'd2:                w = b;                            // likely unlisted opcode
            4'd3:                      w = {`OP_SPECIAL, b[25:0]};       // any funct
            4'd4:                      w = {`OP_REGIMM, b[25:0]};        // any rt
            4'd5:                      w = {`OP_SPECIAL2, b[25:0]};
            4'd6, 4'd7, 4'd8, 4'd9:    w = {`OP_SPECIAL, b[25:6], special_fns[a[31:8] % 26]};
            4'd10:                     w = {`OP_REGIMM, b[25:21], 4'b0, a[8], b[15:0]};
            4'd11:                     w = {`OP_SPECIAL2, b[25:6], `FN_MUL};
            default:                   w = {other_ops[a[31:8] % 22], b[25:0]};
        endcase
    endtask

    // reference decode, built from one flag per instruction class
    task automatic predict_controls(input logic [31:0] w);
        logic [5:0] op, fn;
        logic [4:0] rtf;
        logic nop, sp, shf, vsh, jr, jalr, mfhi, mflo, mthi, mtlo, muldiv, alu_r, mul2;
        logic brn, jmp, jal, alui_s, alui_u, ld, st;
        op = w[31:26];
        fn = w[5:0];
        rtf = w[20:16];
        nop = (w == 32'h0);
        sp = (op == `OP_SPECIAL) && !nop;             // zero word is not an sll
        shf = sp && (fn inside {`FN_SLL, `FN_SRL, `FN_SRA});
        vsh = sp && (fn inside {`FN_SLLV, `FN_SRLV, `FN_SRAV});
        jr = sp && fn == `FN_JR;
        jalr = sp && fn == `FN_JALR;
        mfhi = sp && fn == `FN_MFHI;
        mflo = sp && fn == `FN_MFLO;
        mthi = sp && fn == `FN_MTHI;
        mtlo = sp && fn == `FN_MTLO;
        muldiv = sp && (fn inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU});
        alu_r = sp && (fn inside {`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
                                  `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU});
        mul2 = (op == `OP_SPECIAL2) && fn == `FN_MUL;
        brn = ((op == `OP_REGIMM) && (rtf inside {`RT_BLTZ, `RT_BGEZ})) ||
              (op inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ});
        jmp = op == `OP_J;
        jal = op == `OP_JAL;
        alui_s = op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
        alui_u = op inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
        ld = op inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU};
        st = op inside {`OP_SB, `OP_SH, `OP_SW};
        exp_not_impl = !(nop || shf || vsh || jr || jalr || mfhi || mflo || mthi || mtlo ||
                         muldiv || alu_r || mul2 || brn || jmp || jal || alui_s || alui_u ||
                         ld || st);
        exp_br = brn;
        exp_jp = (jr || jalr) ? `JP_REG : (jmp || jal) ? `JP_IMM : `JP_NONE;
        exp_alu_in_b = shf || alui_s || alui_u || ld || st;
        exp_dm_we = st;
        exp_r_we = shf || vsh || jalr || mfhi || mflo || alu_r || mul2 || jal ||
                   alui_s || alui_u || ld;
        exp_r_dst = jal ? `DST_R31 :
                    (shf || vsh || jalr || mfhi || mflo || alu_r || mul2) ? `DST_RD : `DST_RT;
        exp_rw_d = (jal || jalr) ? `WB_PC : ld ? `WB_MEM : `WB_ALU;
        exp_imm_len = (shf || vsh) ? `LEN_SA : (jmp || jal) ? `LEN_26 : `LEN_16;
        exp_imm_sign_ext = !alui_u;
        exp_mem_size = (op inside {`OP_LB, `OP_LBU, `OP_SB}) ? `SIZE_BYTE :
                       (op inside {`OP_LH, `OP_LHU, `OP_SH}) ? `SIZE_HALF : `SIZE_WORD;
        exp_mem_sign_ext = !(op inside {`OP_LBU, `OP_LHU});
        exp_hi_lo_out = mfhi ? `HL_HI : mflo ? `HL_LO : `HL_ALU;
        exp_hi_in = mthi || muldiv;
        exp_lo_in = mtlo || muldiv;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED time %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_controls();
        check_value("o_br", exp_br, o_br);
        check_value("o_jp", exp_jp, o_jp);
        check_value("o_alu_in_b", exp_alu_in_b, o_alu_in_b);
        check_value("o_dm_we", exp_dm_we, o_dm_we);
        check_value("o_r_we", exp_r_we, o_r_we);
        check_value("o_r_dst", exp_r_dst, o_r_dst);
        check_value("o_rw_d", exp_rw_d, o_rw_d);
        check_value("o_imm_len", exp_imm_len, o_imm_len);
        check_value("o_imm_sign_ext", exp_imm_sign_ext, o_imm_sign_ext);
        check_value("o_mem_size", exp_mem_size, o_mem_size);
        check_value("o_mem_sign_ext", exp_mem_sign_ext, o_mem_sign_ext);
        check_value("o_hi_lo_out", exp_hi_lo_out, o_hi_lo_out);
        check_value("o_hi_in", exp_hi_in, o_hi_in);
        check_value("o_lo_in", exp_lo_in, o_lo_in);
        check_value("o_not_impl", exp_not_impl, o_not_impl);
    endtask

    task automatic compare_fields(input logic [31:0] w, input logic [31:0] p);
        check_value("o_imm16", w[15:0], o_imm16);
        check_value("o_imm26", w[25:0], o_imm26);
        check_value("o_sa", w[10:6], o_sa);
        check_value("o_pc", p, o_pc);
        check_value("o_insn", w, o_insn);
    endtask

    initial begin
        #((RESET_CYCLES + N_INSN + 20) * 4 * 2);
        $display("ERROR: simulation timed out before all instructions were checked");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        i_reset = 1'b1;
        i_insn = '0;
        i_pc = '0;
        repeat (RESET_CYCLES) begin
            gen_insn(word);
            i_insn = word;                // live words during reset must not reach the outputs
            @(posedge clk);
            #1;
        end
        predict_controls(32'h0);          // reset values equal the zero-word decode
        compare_controls();
        i_reset = 1'b0;
        pc = 32'h0040_0000;
        for (int n = 0; n < N_INSN; n++) begin
            gen_insn(word);
            i_insn = word;                // driven 1 ns after the edge
            i_pc = pc;
            #1;
            check_value("o_rs", word[25:21], o_rs);   // same-cycle register numbers
            check_value("o_rt", word[20:16], o_rt);
            @(posedge clk);
            #1;
            predict_controls(word);       // registered outputs follow the word from this edge
            compare_controls();
            compare_fields(word, pc);
            pc = pc + 32'd4;
        end
        $display("checked %0d instructions, %0d errors", N_INSN, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
